/* common/tidc_params.svh */
// Width, size and line-size macros shared by the L1 TileLink adapter
`ifndef TIDC_PARAMS_SVH
`define TIDC_PARAMS_SVH

// ========================================
// Bus and line widths
// ========================================

// Physical address
`define TIDC_ADDR_W 32

// Full cache line held by L1
`define TIDC_LINE_W 256

// One TileLink data beat and its byte mask
`define TIDC_BEAT_W 64
`define TIDC_MASK_W 8

// Source and sink identifiers
`define TIDC_ID_W 4

// ========================================
// Transfer size
// ========================================

// log2 of the line size in bytes, 32 byte line
`define TIDC_LINE_LGSIZE 5

`endif

/* common/tl_pkg.sv */
// TileLink opcode and permission enums, A, C and D channel payload structs
`default_nettype none

`include "tidc_params.svh"

package tl_pkg;

    // ========================================
    // Opcodes per channel
    // ========================================

    typedef enum logic [2:0] {
        A_ACQUIRE_BLOCK = 3'd6
    } a_opcode_e;

    typedef enum logic [2:0] {
        B_PROBE_BLOCK = 3'd6
    } b_opcode_e;

    typedef enum logic [2:0] {
        C_PROBE_ACK      = 3'd4,
        C_PROBE_ACK_DATA = 3'd5,
        C_RELEASE        = 3'd6,
        C_RELEASE_DATA   = 3'd7
    } c_opcode_e;

    typedef enum logic [2:0] {
        D_GRANT       = 3'd4,
        D_GRANT_DATA  = 3'd5,
        D_RELEASE_ACK = 3'd6
    } d_opcode_e;

    // ========================================
    // Permission codes
    // ========================================

    // Shrink and report codes, the widest set
    typedef enum logic [2:0] {
        PRUNE_TTOB  = 3'd0,
        PRUNE_TTON  = 3'd1,
        PRUNE_BTON  = 3'd2,
        REPORT_TTOT = 3'd3,
        REPORT_BTOB = 3'd4,
        REPORT_NTON = 3'd5
    } tl_param_e;

    // Grow and cap codes reuse the same 3-bit field
    localparam tl_param_e GROW_NTOB = tl_param_e'(3'd0);
    localparam tl_param_e GROW_NTOT = tl_param_e'(3'd1);
    localparam tl_param_e GROW_BTOT = tl_param_e'(3'd2);
    localparam tl_param_e CAP_TOT   = tl_param_e'(3'd0);
    localparam tl_param_e CAP_TOB   = tl_param_e'(3'd1);
    localparam tl_param_e CAP_TON   = tl_param_e'(3'd2);

    // ========================================
    // Channel payloads
    // ========================================

    typedef struct packed {
        a_opcode_e                opcode;
        tl_param_e                param;
        logic [3:0]               size;
        logic [`TIDC_ID_W-1:0]    source;
        logic [`TIDC_ADDR_W-1:0]  address;
        logic [`TIDC_BEAT_W-1:0]  data;
        logic [`TIDC_MASK_W-1:0]  mask;
    } tl_a_t;

    typedef struct packed {
        c_opcode_e                opcode;
        tl_param_e                param;
        logic [3:0]               size;
        logic [`TIDC_ID_W-1:0]    source;
        logic [`TIDC_ADDR_W-1:0]  address;
        logic [`TIDC_BEAT_W-1:0]  data;
    } tl_c_t;

    typedef struct packed {
        d_opcode_e                opcode;
        logic [`TIDC_ID_W-1:0]    source;
        logic [`TIDC_ID_W-1:0]    sink;
        logic [`TIDC_BEAT_W-1:0]  data;
        logic                     error;
    } tl_d_t;

endpackage

`default_nettype wire

/* common/l1_pkg.sv */
// L1 request-type enum, L1 request and probe acknowledge structs, transmit command enum
`default_nettype none

`include "tidc_params.svh"

package l1_pkg;

    import tl_pkg::*;

    // Requests the L1 controller can raise
    typedef enum logic [2:0] {
        READ_MISS  = 3'd0,
        WRITE_MISS = 3'd1,
        WRITE_BACK = 3'd2
    } l1_req_e;

    typedef struct packed {
        logic [`TIDC_ADDR_W-1:0]  addr;
        l1_req_e                  req_type;
        tl_param_e                perm;
        logic [`TIDC_LINE_W-1:0]  data;
    } l1_req_t;

    // Resulting permission and dirty line after a probe
    typedef struct packed {
        logic [`TIDC_ADDR_W-1:0]  addr;
        tl_param_e                perm;
        logic [`TIDC_LINE_W-1:0]  data;
    } probe_ack_t;

    // Commands from the FSM to the transmit stage
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        ACQUIRE   = 3'd1,
        GRANT_ACK = 3'd2,
        RELEASE   = 3'd3,
        PROBE_ACK = 3'd4
    } tx_cmd_e;

endpackage

`default_nettype wire

/* l1_tl_adapter/adapter_fsm.sv */
// Control FSM for acquire, release and probe sequencing with B and D decode
`timescale 1ns/10ps
`default_nettype none

`include "tidc_params.svh"

module adapter_fsm import tl_pkg::*, l1_pkg::*; (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [`TIDC_ID_W-1:0]      l1_id,
    input  wire                       l1_req_valid,
    input  wire l1_req_e              l1_req_type,
    input  wire                       b_valid,
    input  wire b_opcode_e            b_opcode,
    input  wire                       d_valid,
    input  wire tl_d_t                d,
    input  wire                       probe_ack_valid,
    input  wire                       tx_done,
    output logic                      l1_req_ready,
    output logic                      b_ready,
    output logic                      d_ready,
    output logic                      cap_req,
    output logic                      cap_probe,
    output logic                      cap_probe_ack,
    output logic                      cap_sink,
    output tx_cmd_e                   tx_cmd,
    output logic                      data_to_l1_valid,
    output logic [`TIDC_LINE_W-1:0]   data_to_l1_data,
    output logic                      data_to_l1_error,
    output logic                      probe_req_valid
);

    typedef enum logic [3:0] {
        IDLE,
        ACQ_SEND,
        ACQ_WAIT,
        GACK_SEND,
        REL_SEND,
        REL_WAIT,
        PRB_FWD,
        PRB_WAIT,
        PACK_SEND
    } state_e;

    state_e   state;
    state_e   state_d;
    tx_cmd_e  cmd_d;
    logic     idle_q;
    logic     req_take;
    logic     probe_take;
    logic     d_ours;
    logic     grant_hit;
    logic     rel_ack_hit;

    // ========================================
    // Handshakes and D decode
    // ========================================

    // Requests win over probes when both are waiting
    assign l1_req_ready = idle_q;
    assign b_ready      = idle_q & ~l1_req_valid;
    assign req_take     = l1_req_valid & idle_q;
    assign probe_take   = b_valid & b_ready & (b_opcode == B_PROBE_BLOCK);

    // A response may land in the same cycle the transmit stage reports done
    assign d_ours      = d_valid & d_ready & (d.source == l1_id);
    assign grant_hit   = d_ours & (d.opcode == D_GRANT || d.opcode == D_GRANT_DATA) &
                         (state == ACQ_WAIT || (state == ACQ_SEND && tx_done));
    assign rel_ack_hit = d_ours & (d.opcode == D_RELEASE_ACK) &
                         (state == REL_WAIT || (state == REL_SEND && tx_done));

    assign cap_req       = req_take;
    assign cap_probe     = probe_take;
    assign cap_probe_ack = (state == PRB_WAIT) & probe_ack_valid;
    assign cap_sink      = grant_hit;

    // ========================================
    // Next state
    // ========================================

    always_comb begin
        state_d = state;
        cmd_d   = NONE;
        case (state)
            IDLE: begin
                if (req_take) begin
                    case (l1_req_type)
                        READ_MISS, WRITE_MISS: begin
                            state_d = ACQ_SEND;
                            cmd_d   = ACQUIRE;
                        end
                        WRITE_BACK: begin
                            state_d = REL_SEND;
                            cmd_d   = RELEASE;
                        end
                        // Unknown codes are taken and dropped
                        default: state_d = IDLE;
                    endcase
                end else if (probe_take) begin
                    state_d = PRB_FWD;
                end
            end
            ACQ_SEND, ACQ_WAIT: begin
                if (grant_hit) begin
                    state_d = GACK_SEND;
                    cmd_d   = GRANT_ACK;
                end else if (tx_done) begin
                    state_d = ACQ_WAIT;
                end
            end
            REL_SEND, REL_WAIT: begin
                if (rel_ack_hit) begin
                    state_d = IDLE;
                end else if (tx_done) begin
                    state_d = REL_WAIT;
                end
            end
            PRB_FWD: state_d = PRB_WAIT;
            PRB_WAIT: begin
                if (probe_ack_valid) begin
                    state_d = PACK_SEND;
                    cmd_d   = PROBE_ACK;
                end
            end
            GACK_SEND, PACK_SEND: begin
                if (tx_done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= IDLE;
            idle_q           <= 1'b0;
            d_ready          <= 1'b0;
            tx_cmd           <= NONE;
            data_to_l1_valid <= 1'b0;
            probe_req_valid  <= 1'b0;
        end else begin
            state            <= state_d;
            idle_q           <= (state_d == IDLE);
            d_ready          <= 1'b1;
            tx_cmd           <= cmd_d;
            data_to_l1_valid <= grant_hit & (d.opcode == D_GRANT_DATA);
            probe_req_valid  <= probe_take;
        end
    end

    // Only the first beat is forwarded, zero-extended to a line
    always_ff @(posedge clk) begin
        if (grant_hit) begin
            data_to_l1_data  <= {{(`TIDC_LINE_W-`TIDC_BEAT_W){1'b0}}, d.data};
            data_to_l1_error <= d.error;
        end
    end

    // The transmit command is only ever registered into a send state
    a_cmd_in_send: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_cmd != NONE) |-> (state inside {ACQ_SEND, GACK_SEND, REL_SEND, PACK_SEND}));

endmodule

`default_nettype wire

/* l1_tl_adapter/txn_regs.sv */
// Transaction registers for pending request, probe, probe acknowledge and grant sink
`timescale 1ns/10ps
`default_nettype none

`include "tidc_params.svh"

module txn_regs import tl_pkg::*, l1_pkg::*; (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       cap_req,
    input  wire l1_req_t              l1_req,
    input  wire                       cap_probe,
    input  wire [`TIDC_ADDR_W-1:0]    b_address,
    input  wire tl_param_e            b_param,
    input  wire                       cap_probe_ack,
    input  wire probe_ack_t           probe_ack,
    input  wire                       cap_sink,
    input  wire [`TIDC_ID_W-1:0]      d_sink,
    output l1_req_t                   pend_req,
    output probe_ack_t                pend_ack,
    output logic [`TIDC_ID_W-1:0]     grant_sink,
    output logic [`TIDC_ADDR_W-1:0]   probe_req_addr,
    output tl_param_e                 probe_req_param
);

    // Line-sized payloads, held until the next capture of their kind
    always_ff @(posedge clk) begin
        if (cap_req) begin
            pend_req <= l1_req;
        end
        if (cap_probe_ack) begin
            pend_ack <= probe_ack;
        end
    end

    // Probe fields drive the L1 probe port directly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            probe_req_addr  <= '0;
            probe_req_param <= CAP_TON;
            grant_sink      <= '0;
        end else begin
            if (cap_probe) begin
                probe_req_addr  <= b_address;
                probe_req_param <= b_param;
            end
            if (cap_sink) begin
                grant_sink <= d_sink;
            end
        end
    end

    // The FSM raises at most one capture strobe per cycle
    a_one_capture: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({cap_req, cap_probe, cap_probe_ack, cap_sink}));

endmodule

`default_nettype wire

/* l1_tl_adapter/tl_tx.sv */
// Registered A, C and E transmit stage holding each message under back-pressure
`timescale 1ns/10ps
`default_nettype none

`include "tidc_params.svh"

module tl_tx import tl_pkg::*, l1_pkg::*; (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [`TIDC_ID_W-1:0]      l1_id,
    input  wire tx_cmd_e              tx_cmd,
    input  wire l1_req_t              pend_req,
    input  wire probe_ack_t           pend_ack,
    input  wire [`TIDC_ID_W-1:0]      grant_sink,
    input  wire                       a_ready,
    input  wire                       c_ready,
    input  wire                       e_ready,
    output tl_a_t                     a,
    output logic                      a_valid,
    output tl_c_t                     c,
    output logic                      c_valid,
    output logic [`TIDC_ID_W-1:0]     e_sink,
    output logic                      e_valid,
    output logic                      tx_done
);

    tl_a_t  a_next;
    tl_c_t  c_next;
    logic   ack_dirty;
    logic   c_load;

    // ========================================
    // Message build
    // ========================================

    // A tip downgrade carries the dirty line back
    assign ack_dirty = pend_ack.perm inside {PRUNE_TTOB, PRUNE_TTON};
    assign c_load    = (tx_cmd == RELEASE) || (tx_cmd == PROBE_ACK);

    always_comb begin
        a_next.opcode  = A_ACQUIRE_BLOCK;
        a_next.param   = pend_req.perm;
        a_next.size    = 4'(`TIDC_LINE_LGSIZE);
        a_next.source  = l1_id;
        a_next.address = pend_req.addr;
        a_next.data    = '0;
        a_next.mask    = '1;

        c_next.size   = 4'(`TIDC_LINE_LGSIZE);
        c_next.source = l1_id;
        if (tx_cmd == RELEASE) begin
            // A write-back always carries its first beat
            c_next.opcode  = C_RELEASE_DATA;
            c_next.param   = pend_req.perm;
            c_next.address = pend_req.addr;
            c_next.data    = pend_req.data[`TIDC_BEAT_W-1:0];
        end else begin
            c_next.opcode  = ack_dirty ? C_PROBE_ACK_DATA : C_PROBE_ACK;
            c_next.param   = pend_ack.perm;
            c_next.address = pend_ack.addr;
            c_next.data    = ack_dirty ? pend_ack.data[`TIDC_BEAT_W-1:0] : '0;
        end
    end

    // ========================================
    // Valid hold and done pulse
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_valid <= 1'b0;
            c_valid <= 1'b0;
            e_valid <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= (a_valid & a_ready) | (c_valid & c_ready) | (e_valid & e_ready);
            if (tx_cmd == ACQUIRE) begin
                a_valid <= 1'b1;
            end else if (a_ready) begin
                a_valid <= 1'b0;
            end
            if (c_load) begin
                c_valid <= 1'b1;
            end else if (c_ready) begin
                c_valid <= 1'b0;
            end
            if (tx_cmd == GRANT_ACK) begin
                e_valid <= 1'b1;
            end else if (e_ready) begin
                e_valid <= 1'b0;
            end
        end
    end

    // Payload loads only with a new command, so it is stable while waiting
    always_ff @(posedge clk) begin
        if (tx_cmd == ACQUIRE) begin
            a <= a_next;
        end
        if (c_load) begin
            c <= c_next;
        end
        if (tx_cmd == GRANT_ACK) begin
            e_sink <= grant_sink;
        end
    end

    a_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid && !a_ready |=> a_valid && $stable(a));
    a_hold_c: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid && !c_ready |=> c_valid && $stable(c));
    a_hold_e: assert property (@(posedge clk) disable iff (!rst_n)
        e_valid && !e_ready |=> e_valid && $stable(e_sink));

endmodule

`default_nettype wire

/* l1_tl_adapter/l1_tl_adapter.sv */
// L1 TileLink adapter top level joining control FSM, transaction registers and transmit stage
`timescale 1ns/10ps
`default_nettype none

`include "tidc_params.svh"

module l1_tl_adapter import tl_pkg::*, l1_pkg::*; (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [`TIDC_ID_W-1:0]      l1_id,

    // L1 controller side
    input  wire l1_req_t              l1_req,
    input  wire                       l1_req_valid,
    output logic                      l1_req_ready,
    output logic                      data_to_l1_valid,
    output logic [`TIDC_LINE_W-1:0]   data_to_l1_data,
    output logic                      data_to_l1_error,
    output logic                      probe_req_valid,
    output logic [`TIDC_ADDR_W-1:0]   probe_req_addr,
    output tl_param_e                 probe_req_param,
    input  wire probe_ack_t           probe_ack,
    input  wire                       probe_ack_valid,

    // TileLink channels
    output tl_a_t                     a,
    output logic                      a_valid,
    input  wire                       a_ready,
    input  wire                       b_valid,
    input  wire b_opcode_e            b_opcode,
    input  wire tl_param_e            b_param,
    input  wire [`TIDC_ADDR_W-1:0]    b_address,
    output logic                      b_ready,
    output tl_c_t                     c,
    output logic                      c_valid,
    input  wire                       c_ready,
    input  wire tl_d_t                d,
    input  wire                       d_valid,
    output logic                      d_ready,
    output logic [`TIDC_ID_W-1:0]     e_sink,
    output logic                      e_valid,
    input  wire                       e_ready
);

    logic                     cap_req;
    logic                     cap_probe;
    logic                     cap_probe_ack;
    logic                     cap_sink;
    tx_cmd_e                  tx_cmd;
    logic                     tx_done;
    l1_req_t                  pend_req;
    probe_ack_t               pend_ack;
    logic [`TIDC_ID_W-1:0]    grant_sink;

    adapter_fsm i_adapter_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .l1_id            (l1_id),
        .l1_req_valid     (l1_req_valid),
        .l1_req_type      (l1_req.req_type),
        .b_valid          (b_valid),
        .b_opcode         (b_opcode),
        .d_valid          (d_valid),
        .d                (d),
        .probe_ack_valid  (probe_ack_valid),
        .tx_done          (tx_done),
        .l1_req_ready     (l1_req_ready),
        .b_ready          (b_ready),
        .d_ready          (d_ready),
        .cap_req          (cap_req),
        .cap_probe        (cap_probe),
        .cap_probe_ack    (cap_probe_ack),
        .cap_sink         (cap_sink),
        .tx_cmd           (tx_cmd),
        .data_to_l1_valid (data_to_l1_valid),
        .data_to_l1_data  (data_to_l1_data),
        .data_to_l1_error (data_to_l1_error),
        .probe_req_valid  (probe_req_valid)
    );

    txn_regs i_txn_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .cap_req         (cap_req),
        .l1_req          (l1_req),
        .cap_probe       (cap_probe),
        .b_address       (b_address),
        .b_param         (b_param),
        .cap_probe_ack   (cap_probe_ack),
        .probe_ack       (probe_ack),
        .cap_sink        (cap_sink),
        .d_sink          (d.sink),
        .pend_req        (pend_req),
        .pend_ack        (pend_ack),
        .grant_sink      (grant_sink),
        .probe_req_addr  (probe_req_addr),
        .probe_req_param (probe_req_param)
    );

    tl_tx i_tl_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .l1_id      (l1_id),
        .tx_cmd     (tx_cmd),
        .pend_req   (pend_req),
        .pend_ack   (pend_ack),
        .grant_sink (grant_sink),
        .a_ready    (a_ready),
        .c_ready    (c_ready),
        .e_ready    (e_ready),
        .a          (a),
        .a_valid    (a_valid),
        .c          (c),
        .c_valid    (c_valid),
        .e_sink     (e_sink),
        .e_valid    (e_valid),
        .tx_done    (tx_done)
    );

endmodule

`default_nettype wire

/* tb/tb_l1_tl_adapter.sv */
// Testbench for the L1 TileLink adapter with L2 responder, L1 model, reference and checker
`timescale 1ns/10ps
`default_nettype none

`include "tidc_params.svh"

module tb_l1_tl_adapter import tl_pkg::*, l1_pkg::*; ();

    localparam int TIMEOUT = 300;
    localparam logic [3:0] ID = 4'h9;

    logic clk;
    logic rst_n;
    l1_req_t l1_req;
    logic l1_req_valid, l1_req_ready;
    logic data_to_l1_valid, data_to_l1_error;
    logic [`TIDC_LINE_W-1:0] data_to_l1_data;
    logic probe_req_valid;
    logic [`TIDC_ADDR_W-1:0] probe_req_addr;
    tl_param_e probe_req_param;
    probe_ack_t probe_ack;
    logic probe_ack_valid;
    tl_a_t a;
    logic a_valid, a_ready;
    logic b_valid, b_ready;
    b_opcode_e b_opcode;
    tl_param_e b_param;
    logic [`TIDC_ADDR_W-1:0] b_address;
    tl_c_t c;
    logic c_valid, c_ready;
    tl_d_t d;
    logic d_valid, d_ready;
    logic [`TIDC_ID_W-1:0] e_sink;
    logic e_valid, e_ready;

    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int a_cnt = 0;
    int c_cnt = 0;
    int e_cnt = 0;
    int pulse_cnt = 0;
    logic [31:0] seed = 32'd47;
    logic rand_ready = 1'b0;
    logic bad_src_first = 1'b0;
    logic rel_ack_sent = 1'b0;
    tl_a_t exp_a;
    tl_c_t exp_c;
    logic [3:0] exp_sink;
    logic [255:0] exp_l1_data;
    logic exp_l1_error;

    l1_tl_adapter i_l1_tl_adapter (.*, .l1_id(ID));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================
    // Helpers and reference model
    // ========================================

    function automatic logic [15:0] lcg();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];
    endfunction

    function automatic logic random_level();
        logic [15:0] v;
        v = lcg();
        return v[3];
    endfunction

    function automatic logic [63:0] beat_of(logic [31:0] addr);
        return {addr ^ 32'h5a5a_0000, ~addr};
    endfunction

    function automatic logic [3:0] sink_of(logic [31:0] addr);
        return addr[8:5];
    endfunction

    // Expected A for an acquire and expected C for a release
    function automatic tl_a_t ref_acquire(l1_req_t r);
        return '{A_ACQUIRE_BLOCK, r.perm, 4'd5, ID, r.addr, 64'd0, 8'hff};
    endfunction

    function automatic tl_c_t ref_release(l1_req_t r);
        return '{C_RELEASE_DATA, r.perm, 4'd5, ID, r.addr, r.data[63:0]};
    endfunction

    function automatic tl_c_t ref_probe_ack(probe_ack_t p);
        logic dirty;
        dirty = (p.perm == PRUNE_TTOB) || (p.perm == PRUNE_TTON);
        return '{dirty ? C_PROBE_ACK_DATA : C_PROBE_ACK, p.perm, 4'd5, ID, p.addr,
                 dirty ? p.data[63:0] : 64'd0};
    endfunction

    task automatic check_eq(string name, logic [255:0] got, logic [255:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_fault(string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic finish_test(string name, int err_start);
        tests++;
        if (errors != err_start) failed_tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "errors");
    endtask

    // ========================================
    // Ready levels, checker and L2 responder
    // ========================================

    always @(posedge clk) begin
        a_ready <= rand_ready ? random_level() : 1'b1;
        c_ready <= rand_ready ? random_level() : 1'b1;
        e_ready <= rand_ready ? random_level() : 1'b1;
    end

    always @(negedge clk) begin
        if (a_valid && a_ready) begin
            a_cnt++;
            check_eq("a", a, exp_a);
        end
        if (c_valid && c_ready) begin
            c_cnt++;
            check_eq("c", c, exp_c);
        end
        if (e_valid && e_ready) begin
            e_cnt++;
            check_eq("e_sink", e_sink, exp_sink);
        end
        if (data_to_l1_valid) begin
            pulse_cnt++;
            check_eq("data_to_l1_data", data_to_l1_data, exp_l1_data);
            check_eq("data_to_l1_error", data_to_l1_error, exp_l1_error);
        end
    end

    task automatic send_d(d_opcode_e op, logic [3:0] src, logic [3:0] snk, logic [63:0] dat,
                          logic err);
        @(posedge clk);
        d <= '{op, src, snk, dat, err};
        d_valid <= 1'b1;
        @(posedge clk);
        d_valid <= 1'b0;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (a_valid && a_ready) begin
                @(posedge clk);
                if (a.param == GROW_BTOT) begin
                    send_d(D_GRANT, a.source, sink_of(a.address), 64'd0, 1'b0);
                end else begin
                    send_d(D_GRANT_DATA, a.source, sink_of(a.address), beat_of(a.address),
                           a.address[5]);
                end
            end else if (c_valid && c_ready && c.opcode inside {C_RELEASE, C_RELEASE_DATA}) begin
                @(posedge clk);
                if (bad_src_first) begin
                    send_d(D_RELEASE_ACK, c.source ^ 4'h1, 4'h0, 64'd0, 1'b0);
                end
                send_d(D_RELEASE_ACK, c.source, 4'h0, 64'd0, 1'b0);
                rel_ack_sent = 1'b1;
            end
        end
    end

    // ========================================
    // L1 model
    // ========================================

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!l1_req_ready && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n >= TIMEOUT) report_fault("timeout waiting for l1_req_ready");
    endtask

    task automatic issue(l1_req_e kind, tl_param_e perm);
        l1_req_t r;
        r.addr = {lcg(), lcg()} & 32'hffff_ffe0;
        r.req_type = kind;
        r.perm = perm;
        r.data = {lcg(), lcg(), lcg(), lcg(), lcg(), lcg(), lcg(), lcg(),
                  lcg(), lcg(), lcg(), lcg(), lcg(), lcg(), lcg(), lcg()};
        exp_a = ref_acquire(r);
        exp_c = ref_release(r);
        exp_sink = sink_of(r.addr);
        exp_l1_data = {192'd0, beat_of(r.addr)};
        exp_l1_error = r.addr[5];
        rel_ack_sent = 1'b0;
        wait_ready();
        @(posedge clk);
        l1_req <= r;
        l1_req_valid <= 1'b1;
        @(posedge clk);
        l1_req_valid <= 1'b0;
    endtask

    // Busy until the counter moves, with l1_req_ready required low meanwhile
    task automatic wait_count(ref int cnt, input int target, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (cnt < target && n < TIMEOUT) begin
            if (l1_req_ready) report_fault("request accepted while busy");
            n++;
            @(negedge clk);
        end
        if (n >= TIMEOUT) report_fault({"timeout waiting for ", what});
    endtask

    task automatic run_acquire(l1_req_e kind, tl_param_e perm, logic data_expected);
        int a0, e0, p0;
        a0 = a_cnt;
        e0 = e_cnt;
        p0 = pulse_cnt;
        issue(kind, perm);
        wait_count(e_cnt, e0 + 1, "GrantAck");
        wait_ready();
        check_eq("a count", a_cnt - a0, 1);
        check_eq("e count", e_cnt - e0, 1);
        check_eq("data pulses", pulse_cnt - p0, data_expected ? 1 : 0);
    endtask

    task automatic run_release(logic bad_src);
        int c0;
        c0 = c_cnt;
        bad_src_first = bad_src;
        issue(WRITE_BACK, PRUNE_TTON);
        wait_count(c_cnt, c0 + 1, "ReleaseData");
        wait_ready();
        if (!rel_ack_sent) report_fault("release completed before ReleaseAck");
        check_eq("c count", c_cnt - c0, 1);
        bad_src_first = 1'b0;
    endtask

    task automatic run_probe(tl_param_e cap, tl_param_e ack_perm);
        probe_ack_t p;
        int n;
        int c0;
        c0 = c_cnt;
        p.addr = {lcg(), lcg()} & 32'hffff_ffe0;
        p.perm = ack_perm;
        p.data = {lcg(), lcg(), lcg(), lcg(), 192'd0} | 256'h1234_5678_9abc;
        exp_c = ref_probe_ack(p);
        wait_ready();
        @(posedge clk);
        b_address <= p.addr;
        b_param <= cap;
        b_opcode <= B_PROBE_BLOCK;
        b_valid <= 1'b1;
        @(posedge clk);
        b_valid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!probe_req_valid && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n >= TIMEOUT) report_fault("timeout waiting for probe_req_valid");
        check_eq("probe_req_addr", probe_req_addr, p.addr);
        check_eq("probe_req_param", probe_req_param, cap);
        @(posedge clk);
        probe_ack <= p;
        probe_ack_valid <= 1'b1;
        @(posedge clk);
        probe_ack_valid <= 1'b0;
        wait_count(c_cnt, c0 + 1, "ProbeAck");
        wait_ready();
        check_eq("c count", c_cnt - c0, 1);
    endtask

    initial begin
        int e0;
        rst_n = 1'b0;
        l1_req = '0;
        l1_req_valid = 1'b0;
        probe_ack = '0;
        probe_ack_valid = 1'b0;
        a_ready = 1'b1;
        b_valid = 1'b0;
        b_opcode = B_PROBE_BLOCK;
        b_param = CAP_TON;
        b_address = '0;
        c_ready = 1'b1;
        d = '0;
        d_valid = 1'b0;
        e_ready = 1'b1;

        e0 = errors;
        repeat (5) begin
            @(negedge clk);
            check_eq("reset outputs", {a_valid, c_valid, e_valid, data_to_l1_valid,
                     probe_req_valid, l1_req_ready, b_ready, d_ready}, 0);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk);
        check_eq("d_ready", d_ready, 1);
        finish_test("reset", e0);

        e0 = errors;
        run_acquire(READ_MISS, GROW_NTOB, 1'b1);
        finish_test("read miss", e0);
        e0 = errors;
        run_acquire(WRITE_MISS, GROW_BTOT, 1'b0);
        finish_test("write miss grant", e0);
        e0 = errors;
        run_release(1'b1);
        finish_test("write back", e0);

        // Consecutive probes change the cap so a missed capture shows
        e0 = errors;
        run_probe(CAP_TOB, PRUNE_TTOB);
        run_probe(CAP_TON, PRUNE_TTON);
        run_probe(CAP_TOB, PRUNE_TTOB);
        run_probe(CAP_TON, PRUNE_BTON);
        finish_test("probe", e0);

        e0 = errors;
        rand_ready = 1'b1;
        repeat (3) begin
            run_acquire(READ_MISS, GROW_NTOT, 1'b1);
            run_acquire(WRITE_MISS, GROW_BTOT, 1'b0);
            run_release(1'b0);
            run_probe(CAP_TOB, PRUNE_TTOB);
            run_probe(CAP_TON, PRUNE_BTON);
        end
        rand_ready = 1'b0;
        finish_test("back-pressure", e0);

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* l1_tl_adapter.f */
+incdir+common
common/tl_pkg.sv
common/l1_pkg.sv
l1_tl_adapter/adapter_fsm.sv
l1_tl_adapter/txn_regs.sv
l1_tl_adapter/tl_tx.sv
l1_tl_adapter/l1_tl_adapter.sv
tb/tb_l1_tl_adapter.sv

/* Makefile */
# Verilator build and run for the L1 TileLink adapter

VERILATOR ?= verilator
FILELIST  ?= l1_tl_adapter.f
TB_TOP    ?= tb_l1_tl_adapter
RTL_TOP   ?= l1_tl_adapter
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
